// File: source/mem_stage_defs.svh
`ifndef MEM_STAGE_DEFS_SVH
`define MEM_STAGE_DEFS_SVH

// datapath widths
`define MEM_ADDR_W      32
`define MEM_DATA_W      32

// tlb geometry, one page is 4 KiB
`define MEM_TLB_ENTRIES 8
`define MEM_TLB_IDX_W   3
`define MEM_PAGE_BITS   12
`define MEM_VPN_W       (`MEM_ADDR_W - `MEM_PAGE_BITS)

// register slice visible to the stage
`define MEM_REGS        4

// operand kinds, top two bits of every operand select
`define MEM_OPK_REG     2'd0
`define MEM_OPK_IMM     2'd1
`define MEM_OPK_EIP     2'd2
`define MEM_OPK_ADDR1   2'd3

`endif

// File: source/mem_stage_pkg.sv
`include "mem_stage_defs.svh"

package mem_stage_pkg;

    // register view: kind, register index, spare bits
    typedef struct packed {
        logic [1:0] kind;
        logic [1:0] idx;
        logic [3:0] rsvd;
    } op_reg_view_t;

    // immediate view: kind, spare bit, left shift applied to imm
    typedef struct packed {
        logic [1:0] kind;
        logic       rsvd;
        logic [4:0] shamt;
    } op_imm_view_t;

    typedef union packed {
        op_reg_view_t reg_view;
        op_imm_view_t imm_view;
    } op_sel_u;

    typedef struct packed {
        logic                  valid;
        logic                  present;
        logic                  writable;
        logic [`MEM_VPN_W-1:0] vpn;
        logic [`MEM_VPN_W-1:0] pfn;
    } tlb_entry_t;

    // one instruction as delivered by the previous stage
    typedef struct packed {
        logic                                  valid;
        logic [1:0]                            opsize;
        logic                                  df;
        logic                                  is_rep;
        logic [31:0]                           rep_num;
        logic [`MEM_ADDR_W-1:0]                addr1;
        logic [`MEM_ADDR_W-1:0]                addr2;
        logic                                  wr1;
        logic                                  wr2;
        logic [`MEM_ADDR_W-1:0]                seg_limit;
        logic [`MEM_DATA_W-1:0]                imm;
        logic [`MEM_ADDR_W-1:0]                eip;
        logic [`MEM_REGS-1:0][`MEM_DATA_W-1:0] regs;
        op_sel_u                               op1_sel;
        op_sel_u                               op2_sel;
    } mem_in_t;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] vaddr1;
        logic [`MEM_ADDR_W-1:0] vaddr2;
    } mem_iter_t;

    // ie_type bit 0 protection, bit 1 page miss
    typedef struct packed {
        logic       ie;
        logic [1:0] ie_type;
    } exc_t;

    typedef struct packed {
        logic                   valid;
        logic [`MEM_ADDR_W-1:0] paddr1;
        logic [`MEM_ADDR_W-1:0] paddr2;
        logic [`MEM_DATA_W-1:0] op1;
        logic [`MEM_DATA_W-1:0] op2;
        exc_t                   exc;
        logic                   rep_last;
    } mem_out_t;

endpackage

// File: source/rep_sequencer.sv
module rep_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mem_stage_pkg::mem_in_t in,
    input  logic                   fwd_stall,
    input  logic                   last,
    output logic                   busy,
    output logic                   load,
    output logic                   step,
    output logic                   issue,
    output mem_stage_pkg::mem_in_t held
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_RUN  = 1'b1;

    logic state_q;
    logic accept;
    logic rep_start;

    assign busy   = (state_q == ST_RUN);
    assign accept = in.valid && !busy && !fwd_stall;
    assign load   = accept;

    // a rep with a zero count retires at acceptance and emits nothing
    assign rep_start = accept && in.is_rep && (in.rep_num != 32'd0);

    // one iteration per cycle while downstream is free
    assign step  = busy && !fwd_stall;
    assign issue = (accept && !in.is_rep) || step;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else if (rep_start) begin
            state_q <= ST_RUN;
        end else if (step && last) begin
            state_q <= ST_IDLE;
        end
    end

    // accepted instruction, replayed for every iteration of a rep
    always_ff @(posedge clk) begin
        if (accept) begin
            held <= in;
        end
    end

    // RUN is only ever entered by a rep with a nonzero count
    a_step_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> held.is_rep && held.rep_num != 32'd0);

    // back-pressure freezes the iteration, so RUN cannot end under a stall
    a_step_not_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        busy && fwd_stall |=> busy);

endmodule

// File: source/rep_counter.sv
module rep_counter (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load,
    input  logic        step,
    input  logic [31:0] count_init,
    output logic        last
);

    // iterations still to be issued, including the current one
    logic [31:0] count_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count_q <= 32'd0;
        end else if (load) begin
            count_q <= count_init;
        end else if (step) begin
            count_q <= count_q - 32'd1;
        end
    end

    assign last = (count_q == 32'd1);

    // the sequencer must leave RUN on the final iteration
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        step |-> count_q != 32'd0);

endmodule

// File: source/addr_stepper.sv
`include "mem_stage_defs.svh"

module addr_stepper (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  logic                     step,
    input  mem_stage_pkg::mem_in_t   in,
    output mem_stage_pkg::mem_iter_t cur
);

    logic [`MEM_ADDR_W-1:0] addr1_q;
    logic [`MEM_ADDR_W-1:0] addr2_q;
    logic [`MEM_ADDR_W-1:0] size;
    logic [`MEM_ADDR_W-1:0] delta;

    // access size of 1, 2, 4 or 8 bytes
    assign size = `MEM_ADDR_W'(4'd1 << in.opsize);

    // df set walks the strings downward
    assign delta = in.df ? -size : size;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr1_q <= '0;
            addr2_q <= '0;
        end else if (load) begin
            addr1_q <= in.addr1;
            addr2_q <= in.addr2;
        end else if (step) begin
            addr1_q <= addr1_q + delta;
            addr2_q <= addr2_q + delta;
        end
    end

    // bypass on load so a non-rep instruction sees its own addresses
    always_comb begin
        if (load) begin
            cur.vaddr1 = in.addr1;
            cur.vaddr2 = in.addr2;
        end else begin
            cur.vaddr1 = addr1_q;
            cur.vaddr2 = addr2_q;
        end
    end

endmodule

// File: source/tlb_lookup.sv
`include "mem_stage_defs.svh"

module tlb_lookup (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr,
    input  logic [`MEM_TLB_IDX_W-1:0]  wr_idx,
    input  mem_stage_pkg::tlb_entry_t  wr_entry,
    input  mem_stage_pkg::mem_iter_t   vaddr,
    input  logic                       wr1,
    input  logic                       wr2,
    output logic [`MEM_ADDR_W-1:0]     paddr1,
    output logic [`MEM_ADDR_W-1:0]     paddr2,
    output logic [1:0]                 miss,
    output logic [1:0]                 prot
);

    logic [`MEM_TLB_ENTRIES-1:0]      vld_q;
    mem_stage_pkg::tlb_entry_t        ent_q [`MEM_TLB_ENTRIES];
    logic [1:0][`MEM_ADDR_W-1:0]      va;
    logic [1:0][`MEM_ADDR_W-1:0]      pa;
    logic [1:0]                       is_wr;
    logic [1:0][`MEM_TLB_ENTRIES-1:0] hit;

    assign va    = {vaddr.vaddr2, vaddr.vaddr1};
    assign is_wr = {wr2, wr1};

    // valid bits kept apart so reset can flush the whole table
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (wr) begin
            vld_q[wr_idx] <= wr_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr) begin
            ent_q[wr_idx] <= wr_entry;
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic [`MEM_VPN_W-1:0] frame;
        logic                  ro;

        for (genvar i = 0; i < `MEM_TLB_ENTRIES; i++) begin : g_cmp
            assign hit[p][i] = vld_q[i] && ent_q[i].present &&
                               (ent_q[i].vpn == va[p][`MEM_ADDR_W-1:`MEM_PAGE_BITS]);
        end

        // frame and permission of the matching entry
        always_comb begin
            frame = '0;
            ro    = 1'b0;
            for (int i = 0; i < `MEM_TLB_ENTRIES; i++) begin
                if (hit[p][i]) begin
                    frame = ent_q[i].pfn;
                    ro    = !ent_q[i].writable;
                end
            end
        end

        assign miss[p] = ~|hit[p];
        assign prot[p] = is_wr[p] && ro;
        assign pa[p]   = miss[p] ? va[p] : {frame, va[p][`MEM_PAGE_BITS-1:0]};

        // software must never map one page twice
        a_single_match: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(hit[p]));
    end

    assign paddr1 = pa[0];
    assign paddr2 = pa[1];

endmodule

// File: source/exc_check.sv
`include "mem_stage_defs.svh"

module exc_check (
    input  mem_stage_pkg::mem_iter_t vaddr,
    input  logic [1:0]               opsize,
    input  logic [`MEM_ADDR_W-1:0]   seg_limit,
    input  logic [1:0]               miss,
    input  logic [1:0]               prot,
    output mem_stage_pkg::exc_t      exc
);

    logic [3:0]           size;
    logic [`MEM_ADDR_W:0] end1;
    logic [`MEM_ADDR_W:0] end2;
    logic                 lim1;
    logic                 lim2;
    logic [1:0]           ie_type;

    assign size = 4'd1 << opsize;

    // last byte touched, one bit wider so an access near the top cannot wrap
    assign end1 = {1'b0, vaddr.vaddr1} + size - 1'b1;
    assign end2 = {1'b0, vaddr.vaddr2} + size - 1'b1;

    assign lim1 = end1 >= {1'b0, seg_limit};
    assign lim2 = end2 >= {1'b0, seg_limit};

    // limit and tlb write protection share one bit
    assign ie_type[0] = lim1 | lim2 | (|prot);
    assign ie_type[1] = |miss;

    assign exc.ie_type = ie_type;
    assign exc.ie      = |ie_type;

endmodule

// File: source/operand_select.sv
`include "mem_stage_defs.svh"

module operand_select (
    input  mem_stage_pkg::mem_in_t in,
    input  logic [`MEM_ADDR_W-1:0] paddr1,
    output logic [`MEM_DATA_W-1:0] op1,
    output logic [`MEM_DATA_W-1:0] op2
);

    function automatic logic [`MEM_DATA_W-1:0] pick(
        input mem_stage_pkg::op_sel_u sel,
        input mem_stage_pkg::mem_in_t inst,
        input logic [`MEM_ADDR_W-1:0] pa
    );
        logic [`MEM_DATA_W-1:0] val;

        // kind lives in the same two bits of either view
        case (sel.reg_view.kind)
            `MEM_OPK_REG:   val = inst.regs[sel.reg_view.idx];
            `MEM_OPK_IMM:   val = inst.imm << sel.imm_view.shamt;
            `MEM_OPK_EIP:   val = inst.eip;
            `MEM_OPK_ADDR1: val = pa;
        endcase
        return val;
    endfunction

    assign op1 = pick(in.op1_sel, in, paddr1);
    assign op2 = pick(in.op2_sel, in, paddr1);

endmodule

// File: source/mem_stage_top.sv
`include "mem_stage_defs.svh"

module mem_stage_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  mem_stage_pkg::mem_in_t    in,
    input  logic                      fwd_stall,
    input  logic                      tlb_wr,
    input  logic [`MEM_TLB_IDX_W-1:0] tlb_wr_idx,
    input  mem_stage_pkg::tlb_entry_t tlb_wr_entry,
    output logic                      stall,
    output mem_stage_pkg::mem_out_t   out
);

    mem_stage_pkg::mem_in_t   held;
    mem_stage_pkg::mem_in_t   cur_in;
    mem_stage_pkg::mem_iter_t cur_addr;
    mem_stage_pkg::exc_t      exc;
    mem_stage_pkg::mem_out_t  out_q;
    logic                     busy;
    logic                     load;
    logic                     step;
    logic                     issue;
    logic                     last;
    logic [`MEM_ADDR_W-1:0]   paddr1;
    logic [`MEM_ADDR_W-1:0]   paddr2;
    logic [1:0]               miss;
    logic [1:0]               prot;
    logic [`MEM_DATA_W-1:0]   op1;
    logic [`MEM_DATA_W-1:0]   op2;

    // a running rep replays its own copy of the instruction
    assign cur_in = busy ? held : in;
    assign stall  = busy | fwd_stall;

    rep_sequencer i_seq (.clk(clk), .rst_n(rst_n), .in(in), .fwd_stall(fwd_stall), .last(last),
        .busy(busy), .load(load), .step(step), .issue(issue), .held(held));

    rep_counter i_cnt (.clk(clk), .rst_n(rst_n), .load(load), .step(step),
        .count_init(cur_in.rep_num), .last(last));

    addr_stepper i_step (.clk(clk), .rst_n(rst_n), .load(load), .step(step), .in(cur_in),
        .cur(cur_addr));

    tlb_lookup i_tlb (.clk(clk), .rst_n(rst_n), .wr(tlb_wr), .wr_idx(tlb_wr_idx),
        .wr_entry(tlb_wr_entry), .vaddr(cur_addr), .wr1(cur_in.wr1), .wr2(cur_in.wr2),
        .paddr1(paddr1), .paddr2(paddr2), .miss(miss), .prot(prot));

    exc_check i_exc (.vaddr(cur_addr), .opsize(cur_in.opsize), .seg_limit(cur_in.seg_limit),
        .miss(miss), .prot(prot), .exc(exc));

    operand_select i_ops (.in(cur_in), .paddr1(paddr1), .op1(op1), .op2(op2));

    // result register, frozen while downstream stalls
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q.valid    <= 1'b0;
            out_q.rep_last <= 1'b0;
        end else if (!fwd_stall) begin
            out_q.valid    <= issue;
            out_q.rep_last <= step && last;
            if (issue) begin
                out_q.paddr1 <= paddr1;
                out_q.paddr2 <= paddr2;
                out_q.op1    <= op1;
                out_q.op2    <= op2;
                out_q.exc    <= exc;
            end
        end
    end

    assign out = out_q;

endmodule

// File: sim/mem_stage_tb.sv
`include "mem_stage_defs.svh"

module mem_stage_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_BASIC   = 96;
    localparam int NUM_LIMIT   = 40;
    localparam int NUM_STREAM  = 60;
    localparam int NUM_RESET   = 12;
    localparam int NUM_ABORT   = 6;
    // counts 0 to 6 over four sizes and two directions
    localparam int REP_SWEEP   = 21 * 8;
    localparam int ITER_TOTAL  = NUM_BASIC + NUM_LIMIT + REP_SWEEP + NUM_STREAM * 6
                                 + NUM_RESET + NUM_ABORT;
    localparam int CYCLE_LIMIT = 20 * ITER_TOTAL + 200;

    logic                      clk;
    logic                      rst_n;
    mem_stage_pkg::mem_in_t    in;
    logic                      fwd_stall;
    logic                      tlb_wr;
    logic [`MEM_TLB_IDX_W-1:0] tlb_wr_idx;
    mem_stage_pkg::tlb_entry_t tlb_wr_entry;
    logic                      stall;
    mem_stage_pkg::mem_out_t   out;

    mem_stage_pkg::tlb_entry_t shadow [`MEM_TLB_ENTRIES];
    mem_stage_pkg::mem_out_t   exp_q [$];
    bit                        run_q [$];
    integer                    seed = 32'h2571d4e2;
    int                        cycles = 0;

    mem_stage_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in           (in),
        .fwd_stall    (fwd_stall),
        .tlb_wr       (tlb_wr),
        .tlb_wr_idx   (tlb_wr_idx),
        .tlb_wr_entry (tlb_wr_entry),
        .stall        (stall),
        .out          (out)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic stop_with_failure();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("[FAIL] %s got %h expected %h", name, got, want);
        stop_with_failure();
    endtask

    task automatic check_exc(input mem_stage_pkg::exc_t got, input mem_stage_pkg::exc_t want);
        if (got.ie !== want.ie) report_mismatch("out.exc.ie", got.ie, want.ie);
        if (got.ie_type !== want.ie_type) begin
            report_mismatch("out.exc.ie_type", got.ie_type, want.ie_type);
        end
    endtask

    task automatic check_out(input mem_stage_pkg::mem_out_t got,
                             input mem_stage_pkg::mem_out_t want);
        if (got.valid !== want.valid) report_mismatch("out.valid", got.valid, want.valid);
        if (got.paddr1 !== want.paddr1) report_mismatch("out.paddr1", got.paddr1, want.paddr1);
        if (got.paddr2 !== want.paddr2) report_mismatch("out.paddr2", got.paddr2, want.paddr2);
        if (got.op1 !== want.op1) report_mismatch("out.op1", got.op1, want.op1);
        if (got.op2 !== want.op2) report_mismatch("out.op2", got.op2, want.op2);
        if (got.rep_last !== want.rep_last) begin
            report_mismatch("out.rep_last", got.rep_last, want.rep_last);
        end
        check_exc(got.exc, want.exc);
    endtask

    // expected result of iteration k of one instruction
    function automatic mem_stage_pkg::mem_out_t expect_iter(
        input mem_stage_pkg::mem_in_t    inst,
        input int                        k,
        input mem_stage_pkg::tlb_entry_t tlb [`MEM_TLB_ENTRIES]
    );
        mem_stage_pkg::mem_out_t res;
        mem_stage_pkg::op_sel_u  sel;
        logic [31:0]             va [2];
        logic [31:0]             pa [2];
        logic [31:0]             opv [2];
        logic [1:0]              miss;
        logic [1:0]              prot;
        logic                    lim;
        logic [31:0]             size;
        logic [31:0]             off;
        longint unsigned         last_byte;

        size  = 32'd1 << inst.opsize;
        off   = 32'(k) * size;
        va[0] = inst.df ? inst.addr1 - off : inst.addr1 + off;
        va[1] = inst.df ? inst.addr2 - off : inst.addr2 + off;
        lim   = 1'b0;
        for (int p = 0; p < 2; p++) begin
            miss[p] = 1'b1;
            prot[p] = 1'b0;
            pa[p]   = va[p];
            for (int i = 0; i < `MEM_TLB_ENTRIES; i++) begin
                if (tlb[i].valid && tlb[i].present && tlb[i].vpn == va[p][31:12]) begin
                    miss[p] = 1'b0;
                    pa[p]   = {tlb[i].pfn, va[p][11:0]};
                    prot[p] = ((p == 0) ? inst.wr1 : inst.wr2) && !tlb[i].writable;
                end
            end
            // last byte of the access must stay below the limit
            last_byte = 64'(va[p]) + 64'(size) - 64'd1;
            if (last_byte >= 64'(inst.seg_limit)) begin
                lim = 1'b1;
            end
        end
        for (int j = 0; j < 2; j++) begin
            sel = (j == 0) ? inst.op1_sel : inst.op2_sel;
            case (sel.imm_view.kind)
                2'd0:    opv[j] = inst.regs[sel.reg_view.idx];
                2'd1:    opv[j] = inst.imm << sel.imm_view.shamt;
                2'd2:    opv[j] = inst.eip;
                default: opv[j] = pa[0];
            endcase
        end
        res.valid       = 1'b1;
        res.paddr1      = pa[0];
        res.paddr2      = pa[1];
        res.op1         = opv[0];
        res.op2         = opv[1];
        res.exc.ie_type = {miss[0] | miss[1], lim | prot[0] | prot[1]};
        res.exc.ie      = |res.exc.ie_type;
        res.rep_last    = inst.is_rep && (32'(k) == inst.rep_num - 32'd1);
        return res;
    endfunction

    function automatic logic [31:0] random_addr();
        logic [19:0] vpn;
        // twelve candidate pages, eight of them programmed into the tlb
        vpn = 20'h00100 + 20'($unsigned($random(seed)) % 12);
        return {vpn, 12'($random(seed))};
    endfunction

    function automatic mem_stage_pkg::mem_in_t random_inst();
        mem_stage_pkg::mem_in_t inst;
        inst.valid     = 1'b1;
        inst.opsize    = 2'($random(seed));
        inst.df        = 1'($random(seed));
        inst.is_rep    = 1'b0;
        inst.rep_num   = $random(seed);
        inst.addr1     = random_addr();
        inst.addr2     = random_addr();
        inst.wr1       = 1'($random(seed));
        inst.wr2       = 1'($random(seed));
        inst.seg_limit = 32'hffff_ffff;
        inst.imm       = $random(seed);
        inst.eip       = $random(seed);
        for (int r = 0; r < `MEM_REGS; r++) begin
            inst.regs[r] = $random(seed);
        end
        inst.op1_sel   = 8'($random(seed));
        inst.op2_sel   = 8'($random(seed));
        return inst;
    endfunction

    // hold the instruction until a cycle without stall, then queue its results
    task automatic send_inst(input mem_stage_pkg::mem_in_t inst, input int stall_pct);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            in        = inst;
            fwd_stall = ($unsigned($random(seed)) % 100) < stall_pct;
            #1;
            accepted  = !stall;
        end
        if (inst.is_rep) begin
            for (int k = 0; k < int'(inst.rep_num); k++) begin
                exp_q.push_back(expect_iter(inst, k, shadow));
                run_q.push_back(32'(k) != inst.rep_num - 32'd1);
            end
        end else begin
            exp_q.push_back(expect_iter(inst, 0, shadow));
            run_q.push_back(1'b0);
        end
    endtask

    task automatic drain();
        do begin
            @(negedge clk);
            in.valid  = 1'b0;
            fwd_stall = 1'b0;
            #1;
        end while (exp_q.size() != 0 || stall);
    endtask

    task automatic program_tlb();
        mem_stage_pkg::tlb_entry_t e;
        for (int i = 0; i < `MEM_TLB_ENTRIES; i++) begin
            e.valid    = (i != 6);
            e.present  = (i != 5);
            e.writable = (i % 3 != 0);
            e.vpn      = 20'h00100 + 20'(i);
            e.pfn      = 20'($random(seed));
            @(negedge clk);
            tlb_wr       = 1'b1;
            tlb_wr_idx   = 3'(i);
            tlb_wr_entry = e;
            shadow[i]    = e;
        end
        @(negedge clk);
        tlb_wr = 1'b0;
    endtask

    task automatic release_reset();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < `MEM_TLB_ENTRIES; i++) begin
            shadow[i].valid = 1'b0;
        end
        #1;
        if (out.valid !== 1'b0) report_mismatch("out.valid", out.valid, 1'b0);
        if (stall !== 1'b0) report_mismatch("stall", stall, 1'b0);
    endtask

    // consumes one result at every edge where downstream takes it
    always @(posedge clk) begin
        mem_stage_pkg::mem_out_t want;
        bit                      in_run;
        if (rst_n && out.valid && !fwd_stall) begin
            if (exp_q.size() == 0) begin
                $display("DUT produced a result that no accepted instruction accounts for");
                stop_with_failure();
            end
            want   = exp_q.pop_front();
            in_run = run_q.pop_front();
            check_out(out, want);
            if (in_run && !stall) report_mismatch("stall", stall, 1'b1);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycles, exp_q.size());
            stop_with_failure();
        end
    end

    initial begin
        mem_stage_pkg::mem_in_t inst;
        rst_n        = 1'b0;
        in           = '0;
        fwd_stall    = 1'b0;
        tlb_wr       = 1'b0;
        tlb_wr_idx   = '0;
        tlb_wr_entry = '0;
        for (int i = 0; i < `MEM_TLB_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        release_reset();
        program_tlb();

        // operand kinds, tlb hits, misses and write protection
        repeat (NUM_BASIC) send_inst(random_inst(), 0);
        drain();

        // accesses on both sides of the segment limit
        repeat (NUM_LIMIT) begin
            inst           = random_inst();
            inst.addr2     = inst.addr1 - 32'($unsigned($random(seed)) % 8);
            inst.seg_limit = inst.addr1 + 32'($unsigned($random(seed)) % 24) - 32'd8;
            send_inst(inst, 0);
        end
        drain();

        for (int n = 0; n <= 6; n++) begin
            for (int sz = 0; sz < 4; sz++) begin
                for (int d = 0; d < 2; d++) begin
                    inst         = random_inst();
                    inst.is_rep  = 1'b1;
                    inst.rep_num = 32'(n);
                    inst.opsize  = 2'(sz);
                    inst.df      = 1'(d);
                    send_inst(inst, 0);
                end
            end
        end
        drain();

        // mixed stream under random back-pressure
        repeat (NUM_STREAM) begin
            inst         = random_inst();
            inst.is_rep  = 1'($random(seed));
            inst.rep_num = 32'($unsigned($random(seed)) % 7);
            send_inst(inst, 30);
        end
        drain();

        // reset in the middle of a rep, with a result on out, must flush every tlb entry
        inst         = random_inst();
        inst.is_rep  = 1'b1;
        inst.rep_num = 32'(NUM_ABORT);
        send_inst(inst, 0);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b0;
        in.valid  = 1'b0;
        fwd_stall = 1'b0;
        exp_q.delete();
        run_q.delete();
        release_reset();
        repeat (NUM_RESET) send_inst(random_inst(), 0);
        drain();

        if (exp_q.size() != 0) begin
            $display("%0d expected results never appeared", exp_q.size());
            stop_with_failure();
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

// File: all.f
+incdir+source
source/mem_stage_pkg.sv
source/rep_sequencer.sv
source/rep_counter.sv
source/addr_stepper.sv
source/tlb_lookup.sv
source/exc_check.sv
source/operand_select.sv
source/mem_stage_top.sv
sim/mem_stage_tb.sv

// File: Makefile
VERILATOR   ?= verilator
TOP         ?= mem_stage_tb
FILELIST    ?= all.f
BUILD_DIR   ?= obj_dir
# extra +define+ arguments passed to every Verilator call, empty by default
SEED_DEFINE ?=
LINT_FLAGS  ?= -Wall
SIM_FLAGS   ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) $(SEED_DEFINE) -f $(FILELIST) \
		--top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(SEED_DEFINE) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
